// File: project.f
+incdir+include
rtl/adm_cfg_pkg.sv
rtl/adm_types_pkg.sv
rtl/adm_sync_fifo.sv
rtl/adm_write_ctrl.sv
rtl/admission_top.sv
tb/admission_assert.sv
tb/tb_admission.sv

// File: rtl/adm_cfg_pkg.sv
`default_nettype none

package adm_cfg_pkg;

    localparam int BEAT_W          = 128;                        // one data beat
    localparam int BEATS_PER_CELL  = 4;                          // 64-byte cell
    localparam int BEAT_IDX_W      = $clog2(BEATS_PER_CELL);
    localparam int CELL_PTR_W      = 10;
    localparam int PD_PTR_W        = 10;
    localparam int SRAM_ADDR_W     = CELL_PTR_W + BEAT_IDX_W;    // {cell ptr, beat idx}
    localparam int NUM_PORTS       = 4;
    localparam int PORT_IDX_W      = $clog2(NUM_PORTS);
    localparam int CELL_CNT_W      = 6;
    localparam int CELL_BYTES_LOG2 = 6;                          // 64 bytes per cell
    localparam int PKT_LEN_W       = 11;                         // length in bytes
    localparam int ENTRY_W         = 16;                         // cell-pointer queue entry
    localparam int DROP_CNT_W      = CELL_CNT_W + BEAT_IDX_W;    // beats left to drain

    // both depths are powers of two so pointers wrap naturally
    localparam int DATA_FIFO_DEPTH = 256;
    localparam int DESC_FIFO_DEPTH = 32;
    localparam int DATA_CNT_W      = $clog2(DATA_FIFO_DEPTH + 1);

    // leaves headroom for beats still in flight upstream
    localparam int BP_THRESHOLD    = 161;

    localparam logic [ENTRY_W-1:0] PREV_NONE = '1;               // prev of a first cell

endpackage

`default_nettype wire

// File: rtl/adm_sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module adm_sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 32
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         i_wr,
    input  wire  [WIDTH-1:0]            i_din,
    input  wire                         i_rd,
    output logic [WIDTH-1:0]            o_dout,
    output logic                        o_empty,
    output logic                        o_full,
    output logic [$clog2(DEPTH+1)-1:0]  o_count
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [AW-1:0]              wr_ptr_q;
    logic [AW-1:0]              rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       wr_ok;
    logic                       rd_ok;

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == ($clog2(DEPTH+1))'(DEPTH));
    assign o_count = count_q;
    assign wr_ok   = i_wr && !o_full;       // write to a full fifo is lost
    assign rd_ok   = i_rd && !o_empty;
    assign o_dout  = mem[rd_ptr_q];         // head word, no read needed

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= i_din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at DEPTH
            end
            if (rd_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/adm_types_pkg.sv
`default_nettype none

package adm_types_pkg;

    import adm_cfg_pkg::*;

    typedef struct packed {
        logic [3:0]            rsvd_hi;
        logic [NUM_PORTS-1:0]  port_map;    // bits 11:8
        logic [1:0]            rsvd_lo;
        logic [CELL_CNT_W-1:0] cell_cnt;    // bits 5:0
    } pkt_desc_t;

    typedef struct packed {
        logic                              last;
        logic                              first;
        logic [ENTRY_W-CELL_PTR_W-3:0]     zero;
        logic [CELL_PTR_W-1:0]             ptr;
    } cell_entry_t;

    typedef struct packed {
        logic                   we;
        logic [SRAM_ADDR_W-1:0] addr;
        logic [BEAT_W-1:0]      data;
    } sram_wr_t;

    typedef struct packed {
        logic [NUM_PORTS-1:0] mask;         // one write enable per port
        cell_entry_t          entry;
        cell_entry_t          prev;
    } qc_push_t;

    typedef struct packed {
        logic [PKT_LEN_W-1:0]  pkt_len;
        logic [CELL_CNT_W-1:0] cell_cnt;
        logic [PD_PTR_W-1:0]   pd_ptr;
    } pd_entry_t;

    typedef struct packed {
        logic [NUM_PORTS-1:0] mask;
        pd_entry_t            entry;
    } pd_push_t;

    typedef struct packed {
        logic                  strobe;
        logic [PORT_IDX_W-1:0] port;
        logic [PKT_LEN_W-1:0]  pkt_len;
    } stat_t;

    typedef enum logic [2:0] {
        IDLE, WAIT_FIRST, BEAT0, BEAT1, BEAT2, BEAT3, DROP
    } wr_state_e;

endpackage

`default_nettype wire

// File: rtl/adm_write_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module adm_write_ctrl
    import adm_cfg_pkg::*, adm_types_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    // descriptor fifo
    input  wire pkt_desc_t         i_desc,
    input  wire                    i_desc_empty,
    output logic                   o_desc_rd,
    // data fifo
    input  wire  [BEAT_W-1:0]      i_beat,
    input  wire                    i_beat_empty,
    output logic                   o_beat_rd,
    // free lists
    input  wire                    i_fq_empty,
    input  wire  [CELL_PTR_W-1:0]  i_fq_ptr,
    output logic                   o_fq_rd,
    input  wire                    i_pdq_empty,
    input  wire  [PD_PTR_W-1:0]    i_pdq_ptr,
    output logic                   o_pdq_rd,
    // queues
    input  wire                    i_qc_full,
    input  wire                    i_pdqc_full,
    output qc_push_t               o_qc_push,
    output pd_push_t               o_pd_push,
    // misc
    input  wire  [NUM_PORTS-1:0]   i_bitmap,
    output sram_wr_t               o_sram,
    output stat_t                  o_stat
);

    wr_state_e               state_q;
    pkt_desc_t               desc_q;
    logic [CELL_CNT_W-1:0]   cells_left_q;
    logic [DROP_CNT_W-1:0]   drop_left_q;
    logic [CELL_PTR_W-1:0]   cell_ptr_q;
    logic [PD_PTR_W-1:0]     pd_ptr_q;
    logic                    first_q;
    cell_entry_t             prev_q;

    logic [NUM_PORTS-1:0]    qc_mask_q;
    cell_entry_t             qc_entry_q;
    cell_entry_t             qc_prev_q;
    logic [NUM_PORTS-1:0]    pd_mask_q;
    pd_entry_t               pd_entry_q;
    logic                    stat_stb_q;
    logic [PORT_IDX_W-1:0]   stat_port_q;

    logic                    admit;
    logic                    drop_pkt;
    logic                    take_ptrs;
    logic                    last_cell;
    logic                    beat_pop;
    logic [BEAT_IDX_W-1:0]   beat_idx;
    logic [PKT_LEN_W-1:0]    pkt_len;
    logic [PORT_IDX_W-1:0]   top_port;
    cell_entry_t             cur_entry;

    assign admit = (state_q == IDLE) && !i_desc_empty && !i_qc_full && !i_pdqc_full &&
                   !i_fq_empty && !i_pdq_empty;
    assign drop_pkt  = ((desc_q.port_map & i_bitmap) == '0) || (desc_q.cell_cnt == '0);
    assign take_ptrs = (state_q == WAIT_FIRST) && !drop_pkt && !i_fq_empty && !i_pdq_empty;
    assign last_cell = (cells_left_q == CELL_CNT_W'(1));
    assign pkt_len   = PKT_LEN_W'({desc_q.cell_cnt, {CELL_BYTES_LOG2{1'b0}}});

    always_comb begin
        case (state_q)
            BEAT0, BEAT1, BEAT2: beat_pop = !i_beat_empty;
            BEAT3:   beat_pop = !i_beat_empty && (last_cell || !i_fq_empty); // next ptr ready
            DROP:    beat_pop = !i_beat_empty && (drop_left_q != '0);
            default: beat_pop = 1'b0;
        endcase
        case (state_q)
            BEAT1:   beat_idx = BEAT_IDX_W'(1);
            BEAT2:   beat_idx = BEAT_IDX_W'(2);
            BEAT3:   beat_idx = BEAT_IDX_W'(3);
            default: beat_idx = '0;
        endcase
        top_port = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (desc_q.port_map[p]) begin
                top_port = PORT_IDX_W'(p);      // highest set bit wins
            end
        end
        cur_entry.last  = last_cell;
        cur_entry.first = first_q;
        cur_entry.zero  = '0;
        cur_entry.ptr   = cell_ptr_q;
    end

    assign o_desc_rd = admit;
    assign o_beat_rd = beat_pop;
    assign o_fq_rd   = take_ptrs || ((state_q == BEAT3) && beat_pop && !last_cell);
    assign o_pdq_rd  = take_ptrs;

    always_comb begin
        o_sram.we   = beat_pop && (state_q != DROP);
        o_sram.addr = {cell_ptr_q, beat_idx};
        o_sram.data = i_beat;
    end

    assign o_qc_push = '{mask: qc_mask_q, entry: qc_entry_q, prev: qc_prev_q};
    assign o_pd_push = '{mask: pd_mask_q, entry: pd_entry_q};
    assign o_stat    = '{strobe: stat_stb_q, port: stat_port_q, pkt_len: pd_entry_q.pkt_len};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q      <= IDLE;
            cells_left_q <= '0;
            drop_left_q  <= '0;
            first_q      <= 1'b0;
            qc_mask_q    <= '0;
            pd_mask_q    <= '0;
            stat_stb_q   <= 1'b0;
        end else begin
            qc_mask_q  <= '0;                   // pushes are single-cycle
            pd_mask_q  <= '0;
            stat_stb_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (admit) begin
                        state_q <= WAIT_FIRST;
                    end
                end
                WAIT_FIRST: begin
                    if (drop_pkt) begin
                        drop_left_q <= {desc_q.cell_cnt, {BEAT_IDX_W{1'b0}}};
                        state_q     <= DROP;
                    end else if (take_ptrs) begin
                        cells_left_q <= desc_q.cell_cnt;
                        first_q      <= 1'b1;
                        state_q      <= BEAT0;
                    end
                end
                BEAT0: begin
                    if (beat_pop) begin
                        qc_mask_q <= desc_q.port_map;
                        first_q   <= 1'b0;
                        if (first_q) begin
                            pd_mask_q  <= desc_q.port_map;
                            stat_stb_q <= 1'b1;
                        end
                        state_q <= BEAT1;
                    end
                end
                BEAT1: if (beat_pop) state_q <= BEAT2;
                BEAT2: if (beat_pop) state_q <= BEAT3;
                BEAT3: begin
                    if (beat_pop) begin
                        cells_left_q <= cells_left_q - 1'b1;
                        state_q      <= last_cell ? IDLE : BEAT0;
                    end
                end
                DROP: begin
                    if (drop_left_q == '0) begin
                        state_q <= IDLE;
                    end else if (beat_pop) begin
                        drop_left_q <= drop_left_q - 1'b1;
                        if (drop_left_q == DROP_CNT_W'(1)) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (admit) begin
            desc_q <= i_desc;
        end
        if (o_fq_rd) begin
            cell_ptr_q <= i_fq_ptr;
        end
        if (o_pdq_rd) begin
            pd_ptr_q <= i_pdq_ptr;
        end
        if ((state_q == BEAT0) && beat_pop) begin
            qc_entry_q <= cur_entry;
            qc_prev_q  <= first_q ? cell_entry_t'(PREV_NONE) : prev_q;
            prev_q     <= cur_entry;            // predecessor for the next cell
            if (first_q) begin
                pd_entry_q  <= '{pkt_len: pkt_len, cell_cnt: desc_q.cell_cnt, pd_ptr: pd_ptr_q};
                stat_port_q <= top_port;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/admission_top.sv
`timescale 1ns/10ps
`default_nettype none

module admission_top
    import adm_cfg_pkg::*, adm_types_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    // upstream
    input  wire                    i_beat_wr,
    input  wire  [BEAT_W-1:0]      i_beat,
    input  wire                    i_desc_wr,
    input  wire pkt_desc_t         i_desc,
    output logic                   o_bp,
    // free lists
    input  wire                    i_fq_empty,
    input  wire  [CELL_PTR_W-1:0]  i_fq_ptr,
    output logic                   o_fq_rd,
    input  wire                    i_pdq_empty,
    input  wire  [PD_PTR_W-1:0]    i_pdq_ptr,
    output logic                   o_pdq_rd,
    // queues and sram
    input  wire                    i_qc_full,
    input  wire                    i_pdqc_full,
    input  wire  [NUM_PORTS-1:0]   i_bitmap,
    output sram_wr_t               o_sram,
    output qc_push_t               o_qc_push,
    output pd_push_t               o_pd_push,
    output stat_t                  o_stat
);

    logic [BEAT_W-1:0]     beat_dout;
    logic                  beat_empty;
    logic                  beat_rd;
    logic [DATA_CNT_W-1:0] beat_cnt;
    pkt_desc_t             desc_dout;
    logic                  desc_empty;
    logic                  desc_full;
    logic                  desc_rd;

    adm_sync_fifo #(
        .WIDTH (BEAT_W),
        .DEPTH (DATA_FIFO_DEPTH)
    ) u_beat_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .i_wr    (i_beat_wr),
        .i_din   (i_beat),
        .i_rd    (beat_rd),
        .o_dout  (beat_dout),
        .o_empty (beat_empty),
        .o_full  (),                        // covered by o_bp threshold
        .o_count (beat_cnt)
    );

    adm_sync_fifo #(
        .WIDTH ($bits(pkt_desc_t)),
        .DEPTH (DESC_FIFO_DEPTH)
    ) u_desc_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .i_wr    (i_desc_wr),
        .i_din   (i_desc),
        .i_rd    (desc_rd),
        .o_dout  (desc_dout),
        .o_empty (desc_empty),
        .o_full  (desc_full),
        .o_count ()
    );

    adm_write_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_desc       (desc_dout),
        .i_desc_empty (desc_empty),
        .o_desc_rd    (desc_rd),
        .i_beat       (beat_dout),
        .i_beat_empty (beat_empty),
        .o_beat_rd    (beat_rd),
        .i_fq_empty   (i_fq_empty),
        .i_fq_ptr     (i_fq_ptr),
        .o_fq_rd      (o_fq_rd),
        .i_pdq_empty  (i_pdq_empty),
        .i_pdq_ptr    (i_pdq_ptr),
        .o_pdq_rd     (o_pdq_rd),
        .i_qc_full    (i_qc_full),
        .i_pdqc_full  (i_pdqc_full),
        .o_qc_push    (o_qc_push),
        .o_pd_push    (o_pd_push),
        .i_bitmap     (i_bitmap),
        .o_sram       (o_sram),
        .o_stat       (o_stat)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_bp <= 1'b0;
        end else begin
            o_bp <= (beat_cnt > DATA_CNT_W'(BP_THRESHOLD)) || desc_full;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the admission testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_admission -o Vtb_admission

./obj_dir/Vtb_admission 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: tb/admission_assert.sv
`timescale 1ns/10ps
`default_nettype none

module admission_assert
    import adm_cfg_pkg::*, adm_types_pkg::*;
(
    input wire            clk,
    input wire            rstn,
    input wire wr_state_e i_state,     // controller state
    input wire sram_wr_t  i_sram,
    input wire qc_push_t  i_qc_push,
    input wire stat_t     i_stat,
    input wire            i_fq_rd,
    input wire            i_fq_empty
);

    a_drop_quiet: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == DROP) |-> !(i_sram.we || (i_qc_push.mask != '0)))
        else $error("sram write or queue push while dropping");

    a_stat_single: assert property (@(posedge clk) disable iff (!rstn)
        i_stat.strobe |=> !i_stat.strobe)
        else $error("statistics strobe wider than one cycle");

    a_fq_rd_empty: assert property (@(posedge clk) disable iff (!rstn)
        !(i_fq_rd && i_fq_empty))
        else $error("free cell pointer read from an empty list");

endmodule

bind admission_top admission_assert u_assert (
    .clk        (clk),
    .rstn       (rstn),
    .i_state    (u_ctrl.state_q),
    .i_sram     (o_sram),
    .i_qc_push  (o_qc_push),
    .i_stat     (o_stat),
    .i_fq_rd    (o_fq_rd),
    .i_fq_empty (i_fq_empty)
);

`default_nettype wire

// File: include/adm_tb_checks.svh
`ifndef ADM_TB_CHECKS_SVH
`define ADM_TB_CHECKS_SVH

int unsigned chk_pass_cnt = 0;
int unsigned chk_err_cnt  = 0;

function automatic void chk_result(input bit ok, input string tag, input string detail);
    if (ok) begin
        chk_pass_cnt++;
    end else begin
        chk_err_cnt++;
        $display("ERROR %s: %s", tag, detail);
    end
endfunction

task automatic check_sram(input sram_wr_t got, input sram_wr_t exp, input string tag);
    chk_result(got === exp, tag, $sformatf("o_sram we/addr/data got %h/%h/%h exp %h/%h/%h",
               got.we, got.addr, got.data, exp.we, exp.addr, exp.data));
endtask

task automatic check_entry(input cell_entry_t got, input cell_entry_t exp, input string name,
                           input string tag);
    chk_result(got === exp, tag, $sformatf("%s got %h exp %h", name, got, exp));
endtask

task automatic check_pd(input pd_entry_t got, input pd_entry_t exp, input string tag);
    chk_result(got === exp, tag, $sformatf(
               "o_pd_push.entry len/cnt/ptr got %h/%h/%h exp %h/%h/%h",
               got.pkt_len, got.cell_cnt, got.pd_ptr, exp.pkt_len, exp.cell_cnt, exp.pd_ptr));
endtask

task automatic check_stat(input stat_t got, input stat_t exp, input string tag);
    chk_result(got === exp, tag, $sformatf("o_stat strobe/port/len got %h/%h/%h exp %h/%h/%h",
               got.strobe, got.port, got.pkt_len, exp.strobe, exp.port, exp.pkt_len));
endtask

`endif

// File: tb/tb_admission.sv
`timescale 1ns/10ps
`default_nettype none

module tb_admission
    import adm_cfg_pkg::*, adm_types_pkg::*;
;

    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = 3000;   // all tests need well under 1000 cycles
    localparam int SETTLE_LIMIT   = 400;    // covers a 168-beat drain
    localparam logic [CELL_PTR_W-1:0] FQ_BASE  = 10'h010;
    localparam logic [PD_PTR_W-1:0]   PDQ_BASE = 10'h200;
    localparam logic [NUM_PORTS-1:0]  BITMAP   = 4'b0111;

    logic                  clk;
    logic                  rstn;
    logic                  i_beat_wr;
    logic [BEAT_W-1:0]     i_beat;
    logic                  i_desc_wr;
    pkt_desc_t             i_desc;
    logic                  o_bp;
    logic                  i_fq_empty;
    logic [CELL_PTR_W-1:0] i_fq_ptr;
    logic                  o_fq_rd;
    logic                  i_pdq_empty;
    logic [PD_PTR_W-1:0]   i_pdq_ptr;
    logic                  o_pdq_rd;
    logic                  i_qc_full;
    logic                  i_pdqc_full;
    logic [NUM_PORTS-1:0]  i_bitmap;
    sram_wr_t              o_sram;
    qc_push_t              o_qc_push;
    pd_push_t              o_pd_push;
    stat_t                 o_stat;

    int                    seed = 32'hdcd2;
    int unsigned           cycle_cnt = 0;
    int unsigned           fq_pops = 0;     // pointer pops seen at posedge
    int unsigned           pdq_pops = 0;
    int unsigned           fq_shown = 0;    // pops applied to the model at negedge
    int unsigned           pdq_shown = 0;
    logic [CELL_PTR_W-1:0] exp_fq;
    logic [PD_PTR_W-1:0]   exp_pd;

    logic [BEAT_W-1:0]     sent_beats[$];
    sram_wr_t              got_sram[$];
    sram_wr_t              exp_sram[$];
    qc_push_t              got_qc[$];
    qc_push_t              exp_qc[$];
    pd_push_t              got_pd[$];
    pd_push_t              exp_pd_push[$];
    stat_t                 got_stat[$];
    stat_t                 exp_stat[$];

    `include "adm_tb_checks.svh"

    admission_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // free lists hand out consecutive pointers
    assign i_fq_ptr  = CELL_PTR_W'(FQ_BASE + fq_shown);
    assign i_pdq_ptr = PD_PTR_W'(PDQ_BASE + pdq_shown);

    always @(negedge clk) begin
        fq_shown  <= fq_pops;
        pdq_shown <= pdq_pops;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (rstn) begin
            if (o_fq_rd) fq_pops++;
            if (o_pdq_rd) pdq_pops++;
            if (o_sram.we) got_sram.push_back(o_sram);
            if (o_qc_push.mask != '0) got_qc.push_back(o_qc_push);
            if (o_pd_push.mask != '0) got_pd.push_back(o_pd_push);
            if (o_stat.strobe) got_stat.push_back(o_stat);
        end
    end

    function automatic logic [PORT_IDX_W-1:0] highest_port(input logic [NUM_PORTS-1:0] pm);
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (pm[p]) return PORT_IDX_W'(p);
        end
        return '0;
    endfunction

    function automatic void expect_low(input logic [NUM_PORTS-1:0] v, input string name);
        chk_result(v === '0, "reset", $sformatf("%s got %h exp 0", name, v));
    endfunction

    task automatic drive_beats(input int n);
        logic [BEAT_W-1:0] beat;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            beat      = {$random(seed), $random(seed), $random(seed), $random(seed)};
            i_beat_wr = 1'b1;
            i_beat    = beat;
            sent_beats.push_back(beat);
        end
        @(negedge clk);
        i_beat_wr = 1'b0;
    endtask

    task automatic drive_desc(input logic [NUM_PORTS-1:0] pm, input int n);
        @(negedge clk);
        i_desc          = '0;
        i_desc.port_map = pm;
        i_desc.cell_cnt = CELL_CNT_W'(n);
        i_desc_wr       = 1'b1;
        @(negedge clk);
        i_desc_wr = 1'b0;
    endtask

    // expected writes and pushes for one packet in arrival order
    task automatic predict_pkt(input logic [NUM_PORTS-1:0] pm, input int n);
        cell_entry_t       prev;
        cell_entry_t       cur;
        qc_push_t          qc;
        pd_push_t          pd;
        stat_t             st;
        sram_wr_t          wr;
        logic [BEAT_W-1:0] beat;
        if ((pm & BITMAP) == '0) begin
            for (int i = 0; i < n * BEATS_PER_CELL; i++) begin
                beat = sent_beats.pop_front();  // drained without a write
            end
            return;
        end
        prev = cell_entry_t'(PREV_NONE);
        for (int c = 0; c < n; c++) begin
            cur       = '0;
            cur.first = (c == 0);
            cur.last  = (c == n - 1);
            cur.ptr   = exp_fq;
            for (int b = 0; b < BEATS_PER_CELL; b++) begin
                wr.we   = 1'b1;
                wr.addr = {exp_fq, BEAT_IDX_W'(b)};
                wr.data = sent_beats.pop_front();
                exp_sram.push_back(wr);
            end
            qc.mask  = pm;
            qc.entry = cur;
            qc.prev  = prev;
            exp_qc.push_back(qc);
            prev   = cur;
            exp_fq = exp_fq + CELL_PTR_W'(1);
        end
        pd.mask           = pm;
        pd.entry.pkt_len  = PKT_LEN_W'(n * 64);
        pd.entry.cell_cnt = CELL_CNT_W'(n);
        pd.entry.pd_ptr   = exp_pd;
        exp_pd_push.push_back(pd);
        exp_pd     = exp_pd + PD_PTR_W'(1);
        st.strobe  = 1'b1;
        st.port    = highest_port(pm);
        st.pkt_len = PKT_LEN_W'(n * 64);
        exp_stat.push_back(st);
    endtask

    task automatic compare_outputs(input string tag);
        int waited;
        waited = 0;
        while ((got_sram.size() < exp_sram.size() || got_qc.size() < exp_qc.size() ||
                got_pd.size() < exp_pd_push.size() || got_stat.size() < exp_stat.size()) &&
               waited < SETTLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= SETTLE_LIMIT) begin
            chk_result(1'b0, tag, "expected outputs did not all arrive in time");
        end
        repeat (8) @(negedge clk);              // room for anything extra to show up
        chk_result(got_sram.size() == exp_sram.size(), tag, $sformatf(
                   "o_sram.we count got %h exp %h", got_sram.size(), exp_sram.size()));
        chk_result(got_qc.size() == exp_qc.size(), tag, $sformatf(
                   "o_qc_push count got %h exp %h", got_qc.size(), exp_qc.size()));
        chk_result(got_pd.size() == exp_pd_push.size(), tag, $sformatf(
                   "o_pd_push count got %h exp %h", got_pd.size(), exp_pd_push.size()));
        chk_result(got_stat.size() == exp_stat.size(), tag, $sformatf(
                   "o_stat.strobe count got %h exp %h", got_stat.size(), exp_stat.size()));
        for (int i = 0; i < exp_sram.size() && i < got_sram.size(); i++) begin
            check_sram(got_sram[i], exp_sram[i], tag);
        end
        for (int i = 0; i < exp_qc.size() && i < got_qc.size(); i++) begin
            chk_result(got_qc[i].mask === exp_qc[i].mask, tag, $sformatf(
                       "o_qc_push.mask got %h exp %h", got_qc[i].mask, exp_qc[i].mask));
            check_entry(got_qc[i].entry, exp_qc[i].entry, "o_qc_push.entry", tag);
            check_entry(got_qc[i].prev, exp_qc[i].prev, "o_qc_push.prev", tag);
        end
        for (int i = 0; i < exp_pd_push.size() && i < got_pd.size(); i++) begin
            chk_result(got_pd[i].mask === exp_pd_push[i].mask, tag, $sformatf(
                       "o_pd_push.mask got %h exp %h", got_pd[i].mask, exp_pd_push[i].mask));
            check_pd(got_pd[i].entry, exp_pd_push[i].entry, tag);
        end
        for (int i = 0; i < exp_stat.size() && i < got_stat.size(); i++) begin
            check_stat(got_stat[i], exp_stat[i], tag);
        end
        got_sram.delete();
        exp_sram.delete();
        got_qc.delete();
        exp_qc.delete();
        got_pd.delete();
        exp_pd_push.delete();
        got_stat.delete();
        exp_stat.delete();
    endtask

    task automatic test_reset();
        @(negedge clk);
        expect_low(o_bp, "o_bp");
        expect_low(o_fq_rd, "o_fq_rd");
        expect_low(o_pdq_rd, "o_pdq_rd");
        expect_low(o_sram.we, "o_sram.we");
        expect_low(o_qc_push.mask, "o_qc_push.mask");
        expect_low(o_pd_push.mask, "o_pd_push.mask");
        expect_low(o_stat.strobe, "o_stat.strobe");
    endtask

    task automatic test_one_cell();
        drive_desc(4'b0010, 1);
        drive_beats(4);
        predict_pkt(4'b0010, 1);
        compare_outputs("one cell");
    endtask

    task automatic test_three_cells();
        drive_desc(4'b0101, 3);
        drive_beats(12);
        predict_pkt(4'b0101, 3);
        compare_outputs("three cells");
    endtask

    task automatic test_drop();
        drive_desc(4'b1000, 1);                 // misses the bitmap
        drive_beats(4);
        drive_desc(4'b0010, 1);
        drive_beats(4);
        predict_pkt(4'b1000, 1);
        predict_pkt(4'b0010, 1);
        compare_outputs("drop then admit");
    endtask

    // hold one blocking input, check nothing moves, then release it
    task automatic test_blocked(input bit use_fq_empty, input string tag);
        int unsigned pops_before;
        pops_before = fq_pops + pdq_pops;
        @(negedge clk);
        if (use_fq_empty) i_fq_empty = 1'b1;
        else i_qc_full = 1'b1;
        drive_desc(4'b0010, 1);
        drive_beats(4);
        repeat (20) @(negedge clk);
        chk_result(got_sram.size() == 0 && got_qc.size() == 0 &&
                   fq_pops + pdq_pops == pops_before, tag,
                   "a packet was admitted while admission was blocked");
        i_fq_empty = 1'b0;
        i_qc_full  = 1'b0;
        predict_pkt(4'b0010, 1);
        compare_outputs(tag);
    endtask

    task automatic test_backpressure();
        int waited;
        drive_beats(165);
        repeat (2) @(negedge clk);              // o_bp is registered
        chk_result(o_bp === 1'b1, "bp", $sformatf("o_bp got %h exp 1", o_bp));
        drive_beats(3);
        drive_desc(4'b1000, 42);                // dropped packet drains all 168 beats
        predict_pkt(4'b1000, 42);
        waited = 0;
        while (o_bp !== 1'b0 && waited < SETTLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        chk_result(o_bp === 1'b0, "bp", $sformatf("o_bp got %h exp 0", o_bp));
        drive_desc(4'b0010, 1);
        drive_beats(4);
        predict_pkt(4'b0010, 1);
        compare_outputs("after bp drain");
    endtask

    initial begin
        rstn        = 1'b0;
        i_beat_wr   = 1'b0;
        i_beat      = '0;
        i_desc_wr   = 1'b0;
        i_desc      = '0;
        i_fq_empty  = 1'b0;
        i_pdq_empty = 1'b0;
        i_qc_full   = 1'b0;
        i_pdqc_full = 1'b0;
        i_bitmap    = BITMAP;
        exp_fq      = FQ_BASE;
        exp_pd      = PDQ_BASE;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        test_reset();
        test_one_cell();
        test_three_cells();
        test_drop();
        test_blocked(1'b0, "qc full");
        test_blocked(1'b1, "fq empty");
        test_backpressure();
        $display("checks passed %0d, errors %0d", chk_pass_cnt, chk_err_cnt);
        if (chk_err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks passed %0d, errors %0d", chk_pass_cnt, chk_err_cnt);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
